// File: tb.f
+incdir+source
source/icache_pkg.sv
source/icache_ifs.sv
source/icache_tag_store.sv
source/icache_data_store.sv
source/icache_refill_ctrl.sv
source/axi_burst_reader.sv
source/icache_top.sv
tests/tb_pkg.sv
tests/icache_props.sv
tests/icache_checker.sv
tests/tb_top.sv

// File: Makefile
SRCS := $(wildcard source/*.sv source/*.svh tests/*.sv)

obj_dir/Vtb_top: $(SRCS) tb.f
	verilator --binary --timing --assert -f tb.f --top-module tb_top -o Vtb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee sim.log
	! grep -q "Test failed" sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: tests/tb_top.sv
`default_nettype none

`include "icache_params.svh"

module tb_top import tb_pkg::*; ;
  timeunit 1ns;
  timeprecision 100ps;

  localparam longint LIMIT_NS = longint'(N_FETCH) * REFILL_BOUND * CLK_PERIOD + 1000;

  logic                   clock;
  logic                   reset;
  logic                   fence_i;
  logic [31:0]            addr;
  logic                   hit;
  logic [31:0]            inst;
  logic [31:0]            miss_count;
  logic                   arvalid;
  logic                   arready = 1'b0;
  logic [31:0]            araddr;
  logic                   rvalid = 1'b0;
  logic                   rready;
  logic [`AXI_DATA_W-1:0] rdata = '0;
  logic                   rlast = 1'b0;

  logic        bursting;
  logic [31:0] ar_base;
  logic [2:0]  beat_idx;  // next beat to present
  int          fetches;
  int          errors;

  icache_top dut0 (.*);

  icache_checker checker0 (
    .clock(clock), .reset(reset), .fence_i(fence_i), .addr(addr), .hit(hit), .inst(inst),
    .miss_count(miss_count), .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rlast(rlast)
  );

  // 1 KiB window, four tags per set
  function automatic logic [31:0] rand_addr();
    return 32'h0000_2000 | ($urandom_range(0, 255) << 2);
  endfunction

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // AXI slave, 4-beat wrapping bursts with random stalls
  always @(posedge clock) begin : mem_model
    logic [29:0] wa;
    logic [31:0] junk;
    if (reset) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      rlast    <= 1'b0;
      bursting <= 1'b0;
    end else begin
      arready <= ($urandom_range(0, 3) == 0);
      if (arvalid && arready) begin
        ar_base  <= araddr;
        beat_idx <= 3'd0;
        bursting <= 1'b1;
      end
      if (rvalid && rready && rlast) begin
        rvalid   <= 1'b0;
        rlast    <= 1'b0;
        bursting <= 1'b0;
      end else if (bursting && (!rvalid || rready)) begin
        if (beat_idx < 3'd4 && $urandom_range(0, 3) != 0) begin
          wa   = {ar_base[31:4], ar_base[3:2] + beat_idx[1:0]};
          junk = $urandom;
          rdata    <= wa[0] ? {mem_word(wa), junk} : {junk, mem_word(wa)};
          rlast    <= (beat_idx == 3'd3);
          rvalid   <= 1'b1;
          beat_idx <= beat_idx + 3'd1;
        end else begin
          rvalid <= 1'b0;
        end
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    reset   <= 1'b1;
    fence_i <= 1'b0;
    addr    <= rand_addr();
    fetches = 0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    while (fetches < N_FETCH) begin
      @(posedge clock);
      fence_i <= ($urandom_range(0, 99) == 0);  // rare pulse
      if (hit && !reset) begin
        fetches++;
        if (fetches < N_FETCH) addr <= rand_addr();
        else fence_i <= 1'b0;
      end
    end
    // a late fence may have started one more refill
    do @(posedge clock); while (!hit);
    @(negedge clock);  // checker has seen the last edge
    checker0.report(errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(LIMIT_NS);
    $display("timeout: fetches did not complete in time, %0d of %0d done", fetches, N_FETCH);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/icache_checker.sv
`default_nettype none

`include "icache_params.svh"

module icache_checker import icache_pkg::*; import tb_pkg::*; (
  input logic        clock,
  input logic        reset,
  input logic        fence_i,
  input logic [31:0] addr,
  input logic        hit,
  input logic [31:0] inst,
  input logic [31:0] miss_count,
  input logic        arvalid,
  input logic        arready,
  input logic [31:0] araddr,
  input logic        rvalid,
  input logic        rready,
  input logic        rlast
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int T_HIT_DATA = 0;
  localparam int T_HIT_PRED = 1;
  localparam int T_BURST    = 2;
  localparam int T_FENCE    = 3;
  localparam int T_MISS     = 4;

  string names [5] = '{"hit_data", "hit_predict", "burst_addr", "fence", "miss_count"};
  int    checks [5] = '{0, 0, 0, 0, 0};
  int    errs [5] = '{0, 0, 0, 0, 0};

  logic [`ICACHE_SETS-1:0] model_valid;
  logic [`ICACHE_SETS-1:0] stale;  // valid before the last fence, not yet refetched
  icache_tag_t             model_tag [`ICACHE_SETS];
  icache_index_t           fill_index;
  icache_tag_t             fill_tag;
  logic                    ar_waiting;
  logic [31:0]             ar_held;
  logic                    data_phase;  // between AR handshake and the rlast beat
  logic                    req_pending;
  int                      ar_count = 0;
  int                      model_misses = 0;

  function automatic icache_index_t index_of(input logic [31:0] a);
    return a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  endfunction

  function automatic icache_tag_t tag_of(input logic [31:0] a);
    return a[31 -: `ICACHE_TAG_W];
  endfunction

  function automatic logic model_hit(input logic [31:0] a);
    return model_valid[index_of(a)] && (model_tag[index_of(a)] == tag_of(a));
  endfunction

  task automatic note_mismatch(input int t, input logic [31:0] exp, input logic [31:0] act);
    errs[t]++;
    $display("mismatch %s expected %h actual %h", names[t], exp, act);
  endtask

  task automatic note_failure(input int t, input string what);
    errs[t]++;
    $display("%s: %s", names[t], what);
  endtask

  // all values read here are the ones of the cycle just ending
  always @(posedge clock) begin : watch
    icache_index_t idx;
    logic          busy;
    idx  = index_of(addr);
    busy = arvalid | rready;
    if (reset) begin
      model_valid = '0;
      stale       = '0;
      ar_waiting  = 1'b0;
      data_phase  = 1'b0;
      req_pending = 1'b0;
    end else begin
      if (hit) begin
        checks[T_HIT_DATA]++;
        if (inst != mem_word(addr[31:2])) note_mismatch(T_HIT_DATA, mem_word(addr[31:2]), inst);
      end
      if (!busy) begin
        checks[T_HIT_PRED]++;
        if (hit != model_hit(addr)) note_mismatch(T_HIT_PRED, 32'(model_hit(addr)), 32'(hit));
        if (stale[idx]) begin
          checks[T_FENCE]++;
          if (hit) note_failure(T_FENCE, "line still hit after fence_i, no new AR request");
          stale[idx] = 1'b0;
        end
        if (!req_pending && !model_hit(addr)) begin
          model_misses++;
          req_pending = 1'b1;
        end
      end
      if (ar_waiting) begin
        checks[T_BURST]++;
        if (!arvalid) note_failure(T_BURST, "arvalid dropped before arready");
        else if (araddr != ar_held) note_mismatch(T_BURST, ar_held, araddr);
      end
      if (rready || data_phase) begin
        checks[T_BURST]++;
        if (rready != data_phase) note_failure(T_BURST, "rready not held over the data phase");
      end
      if (arvalid && arready) begin
        checks[T_BURST]++;
        if (araddr != {addr[31:2], 2'b00}) note_mismatch(T_BURST, {addr[31:2], 2'b00}, araddr);
        ar_count++;
        fill_index = index_of(araddr);
        fill_tag   = tag_of(araddr);
        stale[fill_index] = 1'b0;
        req_pending = 1'b0;
        data_phase  = 1'b1;
      end
      ar_waiting = arvalid && !arready;
      ar_held    = araddr;
      if (fence_i) begin
        stale       = model_valid;
        model_valid = '0;
      end
      if (rvalid && rready && rlast) begin  // line completes even across a fence
        model_valid[fill_index] = 1'b1;
        model_tag[fill_index]   = fill_tag;
        stale[fill_index]       = 1'b0;
        data_phase              = 1'b0;
      end
    end
  end

  task automatic report(output int total);
    int n;
    checks[T_MISS] += 2;
    if (miss_count != 32'(ar_count)) note_mismatch(T_MISS, 32'(ar_count), miss_count);
    if (ar_count != model_misses) note_mismatch(T_MISS, 32'(model_misses), 32'(ar_count));
    total = 0;
    n     = 0;
    for (int i = 0; i < 5; i++) begin
      $display("%s: %0d checks, %0d errors", names[i], checks[i], errs[i]);
      total += errs[i];
      n     += checks[i];
    end
    $display("summary: 5 tests, %0d checks, %0d errors", n, total);
  endtask

endmodule

`default_nettype wire

// File: tests/icache_props.sv
`default_nettype none

module icache_props (
  input logic clock,
  input logic reset,
  input logic idle,
  input logic hit,
  input logic start,
  input logic word_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  start_pulse: assert property (@(posedge clock) disable iff (reset) start |=> !start)
    else $error("start held for more than one cycle");

  // lookup missed last cycle, still misses, and the FSM has left idle
  start_after_miss: assert property (@(posedge clock) disable iff (reset)
    start |-> $past(!hit) && !hit && !idle)
    else $error("start without a preceding miss");

  no_word_in_idle: assert property (@(posedge clock) disable iff (reset) idle |-> !word_valid)
    else $error("word_valid while the controller is idle");

endmodule

bind icache_refill_ctrl icache_props props0 (
  .clock      (clock),
  .reset      (reset),
  .idle       (state[0]),
  .hit        (hit),
  .start      (rd.start),
  .word_valid (rd.word_valid)
);

`default_nettype wire

// File: tests/tb_pkg.sv
`default_nettype none

package tb_pkg;

  localparam int unsigned SEED         = 32'h95b9;
  localparam int          N_FETCH      = 400;
  localparam int          REFILL_BOUND = 200;  // cycles per fetch, generous for random stalls
  localparam int          CLK_PERIOD   = 8;

  // fixed hash of the word address, stands in for program memory
  function automatic logic [31:0] mem_word(input logic [29:0] waddr);
    logic [31:0] x;
    x = {2'b00, waddr} * 32'h9e3779b1;
    x = x ^ (x >> 15);
    x = x * 32'h85ebca6b;
    return x ^ (x >> 13);
  endfunction

endpackage

`default_nettype wire

// File: source/icache_top.sv
`default_nettype none

`include "icache_params.svh"

module icache_top import icache_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   fence_i,
  input  logic [31:0]            addr,
  output logic                   hit,
  output logic [31:0]            inst,
  output logic [31:0]            miss_count,
  output logic                   arvalid,
  input  logic                   arready,
  output logic [31:0]            araddr,
  input  logic                   rvalid,
  output logic                   rready,
  input  logic [`AXI_DATA_W-1:0] rdata,
  input  logic                   rlast
);

  icache_addr_u lookup_addr;

  refill_if refill_bus ();
  fill_if   fill_bus ();

  assign lookup_addr = icache_addr_u'(addr);

  icache_tag_store tag_store0 (
    .clock       (clock),
    .reset       (reset),
    .fence_i     (fence_i),
    .lookup_addr (lookup_addr),
    .fill        (fill_bus.store),
    .hit         (hit)
  );

  icache_data_store data_store0 (
    .clock       (clock),
    .lookup_addr (lookup_addr),
    .fill        (fill_bus.store),
    .inst        (inst)
  );

  icache_refill_ctrl refill_ctrl0 (
    .clock       (clock),
    .reset       (reset),
    .hit         (hit),
    .lookup_addr (lookup_addr),
    .rd          (refill_bus.master),
    .fill        (fill_bus.writer),
    .miss_count  (miss_count)
  );

  // wrapping 4x4-byte bursts only
  axi_burst_reader reader0 (
    .clock   (clock),
    .reset   (reset),
    .rd      (refill_bus.reader),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rlast   (rlast)
  );

endmodule

`default_nettype wire

// File: source/axi_burst_reader.sv
`default_nettype none

`include "icache_params.svh"

module axi_burst_reader import icache_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  refill_if.reader               rd,
  output logic                   arvalid,
  input  logic                   arready,
  output logic [31:0]            araddr,
  input  logic                   rvalid,
  output logic                   rready,
  input  logic [`AXI_DATA_W-1:0] rdata,
  input  logic                   rlast
);

  localparam int LANE_W = $clog2(`AXI_LANES);

  icache_word_off_t  pos;  // word of the current beat
  logic              beat;
  logic [LANE_W-1:0] lane;

  assign beat = rvalid & rready;
  assign lane = pos[LANE_W-1:0];  // addr bit 2 picks the half

  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid <= 1'b0;
      rready  <= 1'b0;
    end else begin
      if (rd.start) begin
        arvalid <= 1'b1;
      end else if (arvalid && arready) begin
        arvalid <= 1'b0;
        rready  <= 1'b1;
      end else if (beat && rlast) begin
        rready <= 1'b0;
      end
    end
  end

  // held stable through the AR phase
  always_ff @(posedge clock) begin
    if (rd.start) begin
      araddr <= rd.start_addr;
      pos    <= rd.start_addr[`ICACHE_OFFSET_W-1:2];
    end else if (beat) begin
      pos <= pos + 1'b1;
    end
  end

  assign rd.word_valid = beat;
  assign rd.word       = rdata[lane*32 +: 32];
  assign rd.word_last  = beat & rlast;

endmodule

`default_nettype wire

// File: source/icache_refill_ctrl.sv
`default_nettype none

module icache_refill_ctrl import icache_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         hit,
  input  icache_addr_u lookup_addr,
  refill_if.master     rd,
  fill_if.writer       fill,
  output logic [31:0]  miss_count
);

  typedef enum logic [2:0] {
    ST_IDLE = 3'b001,
    ST_BUSY = 3'b010,
    ST_DONE = 3'b100
  } state_t;

  state_t           state;
  state_t           state_next;
  logic             miss;
  icache_word_off_t off;
  icache_index_t    miss_index;
  icache_tag_t      miss_tag;

  assign miss = state[0] & ~hit;  // idle bit

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (~hit) begin
          state_next = ST_BUSY;
        end
      end
      ST_BUSY: begin
        if (rd.word_valid && rd.word_last) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: state_next = ST_IDLE;  // hit comes up here
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= ST_IDLE;
      rd.start   <= 1'b0;
      miss_count <= '0;
    end else begin
      state    <= state_next;
      rd.start <= miss;
      if (miss) begin
        miss_count <= miss_count + 32'd1;  // one AR burst per start
      end
    end
  end

  // miss address, fill position; burst wraps from the requested word
  always_ff @(posedge clock) begin
    if (miss) begin
      rd.start_addr <= {lookup_addr.raw[31:2], 2'b00};
      miss_index    <= lookup_addr.f.index;
      miss_tag      <= lookup_addr.f.tag;
      off           <= lookup_addr.f.word_off;
    end else if (rd.word_valid) begin
      off <= off + 1'b1;  // wraps modulo the line
    end
  end

  assign fill.wr_en    = rd.word_valid;
  assign fill.wr_index = miss_index;
  assign fill.wr_off   = off;
  assign fill.wr_word  = rd.word;
  assign fill.wr_last  = rd.word_last;
  assign fill.wr_tag   = miss_tag;

endmodule

`default_nettype wire

// File: source/icache_data_store.sv
`default_nettype none

`include "icache_params.svh"

module icache_data_store import icache_pkg::*; (
  input  logic         clock,
  input  icache_addr_u lookup_addr,
  fill_if.store        fill,
  output logic [31:0]  inst
);

  logic [31:0] words [`ICACHE_SETS][`ICACHE_WORDS];

  // async read, valid only together with hit
  assign inst = words[lookup_addr.f.index][lookup_addr.f.word_off];

  // one word per accepted beat
  always_ff @(posedge clock) begin
    if (fill.wr_en) begin
      words[fill.wr_index][fill.wr_off] <= fill.wr_word;
    end
  end

endmodule

`default_nettype wire

// File: source/icache_tag_store.sv
`default_nettype none

`include "icache_params.svh"

module icache_tag_store import icache_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         fence_i,
  input  icache_addr_u lookup_addr,
  fill_if.store        fill,
  output logic         hit
);

  logic [`ICACHE_SETS-1:0] valid;
  icache_tag_t             tags [`ICACHE_SETS];
  logic                    fill_done;

  assign fill_done = fill.wr_en & fill.wr_last;

  // direct mapped, one compare
  assign hit = valid[lookup_addr.f.index] & (tags[lookup_addr.f.index] == lookup_addr.f.tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else begin
      if (fence_i) begin
        valid <= '0;
      end
      // later assignment wins, so a line finishing now survives the fence
      if (fill_done) begin
        valid[fill.wr_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill_done) begin
      tags[fill.wr_index] <= fill.wr_tag;
    end
  end

endmodule

`default_nettype wire

// File: source/icache_ifs.sv
`default_nettype none

// miss request and returned words, controller <-> burst reader
interface refill_if;
  logic        start;
  logic [31:0] start_addr;
  logic        word_valid;
  logic [31:0] word;
  logic        word_last;

  modport master (
    output start, start_addr,
    input  word_valid, word, word_last
  );

  modport reader (
    input  start, start_addr,
    output word_valid, word, word_last
  );
endinterface

// per-word line writes into both stores
interface fill_if import icache_pkg::*; ();
  logic             wr_en;
  icache_index_t    wr_index;
  icache_word_off_t wr_off;
  logic [31:0]      wr_word;
  logic             wr_last;
  icache_tag_t      wr_tag;

  modport writer (
    output wr_en, wr_index, wr_off, wr_word, wr_last, wr_tag
  );

  modport store (
    input wr_en, wr_index, wr_off, wr_word, wr_last, wr_tag
  );
endinterface

`default_nettype wire

// File: source/icache_pkg.sv
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

  typedef logic [`ICACHE_TAG_W-1:0] icache_tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] icache_index_t;
  typedef logic [`ICACHE_WORD_OFF_W-1:0] icache_word_off_t;

  // fetch address as the cache sees it
  typedef struct packed {
    icache_tag_t      tag;
    icache_index_t    index;
    icache_word_off_t word_off;
    logic [1:0]       byte_off;  // always zero for fetches
  } icache_addr_t;

  // raw form goes on the bus, split form drives the lookup
  typedef union packed {
    logic [31:0]  raw;
    icache_addr_t f;
  } icache_addr_u;

endpackage

`default_nettype wire

// File: source/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// line geometry: 16-byte lines of 4 words
`define ICACHE_OFFSET_W 4
`define ICACHE_WORD_OFF_W (`ICACHE_OFFSET_W - 2)
`define ICACHE_WORDS (1 << `ICACHE_WORD_OFF_W)

// set geometry
`define ICACHE_INDEX_W 4
`define ICACHE_SETS (1 << `ICACHE_INDEX_W)

// whatever is left of the 32-bit address
`define ICACHE_TAG_W (32 - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// memory side read data bus
`define AXI_DATA_W 64
`define AXI_LANES (`AXI_DATA_W / 32)  // 32-bit lanes per beat

`endif
